// ==== src/fifo_pkg.sv ====
package fifo_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int DATA_WIDTH = 16;

    // Must stay a power of two so the pointers wrap cleanly
    localparam int FIFO_DEPTH = 16;
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    typedef logic [DATA_WIDTH-1:0] fifo_data_t;
    typedef logic [ADDR_WIDTH-1:0] fifo_addr_t;

    ////////////////////
    // Memory ports
    ////////////////////

    typedef struct packed {
        logic       valid;
        fifo_addr_t address;
        fifo_data_t data;
    } memory_write_t;

    typedef struct packed {
        logic       valid;
        fifo_addr_t address;
    } memory_read_t;

    ////////////////////
    // Gray code helpers
    ////////////////////

    function automatic fifo_addr_t binary_to_gray(input fifo_addr_t binary);
        return binary ^ (binary >> 1);
    endfunction

    function automatic fifo_addr_t gray_to_binary(input fifo_addr_t gray);
        fifo_addr_t binary;
        for (int i = 0; i < ADDR_WIDTH; i++) begin
            binary[i] = ^(gray >> i);
        end
        return binary;
    endfunction

endpackage

// ==== src/fifo_write_controller.sv ====
`timescale 1ns/1ps

module fifo_write_controller (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    write_enable,
    input  fifo_pkg::fifo_data_t    write_data,
    input  fifo_pkg::fifo_addr_t    read_pointer_gray,
    output fifo_pkg::memory_write_t write_port,
    output fifo_pkg::fifo_addr_t    write_pointer_gray,
    output logic                    full
);

    import fifo_pkg::*;

    // Binary write pointer to the next free slot
    fifo_addr_t write_pointer;
    fifo_addr_t write_pointer_next;
    fifo_addr_t write_pointer_next_plus_one;

    // Read pointer as seen from the write domain
    fifo_addr_t read_pointer_gray_sync_0;
    fifo_addr_t read_pointer_gray_sync_1;
    fifo_addr_t read_pointer;

    logic       write_accept;
    logic       full_next;

    // Registered memory write
    logic       memory_write_valid;
    fifo_addr_t memory_write_address;
    fifo_data_t memory_write_data;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        read_pointer = gray_to_binary(read_pointer_gray_sync_1);
        write_accept = write_enable && !full;

        write_pointer_next = write_pointer;
        if (write_accept) begin
            // Wraps at FIFO_DEPTH minus 1 through the pointer width
            write_pointer_next = write_pointer + 1'b1;
        end

        // Full uses the pointer after this write and keeps one slot free
        write_pointer_next_plus_one = write_pointer_next + 1'b1;
        full_next = (write_pointer_next_plus_one == read_pointer);
    end

    ////////////////////
    // Control registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer            <= '0;
            write_pointer_gray       <= '0;
            read_pointer_gray_sync_0 <= '0;
            read_pointer_gray_sync_1 <= '0;
            memory_write_valid       <= 1'b0;
            full                     <= 1'b0;
        end
        else begin
            write_pointer            <= write_pointer_next;
            write_pointer_gray       <= binary_to_gray(write_pointer_next);
            read_pointer_gray_sync_0 <= read_pointer_gray;
            read_pointer_gray_sync_1 <= read_pointer_gray_sync_0;
            memory_write_valid       <= write_accept;
            full                     <= full_next;
        end
    end

    // Write payload qualified by memory_write_valid
    always_ff @(posedge clock) begin
        if (write_accept) begin
            memory_write_address <= write_pointer;
            memory_write_data    <= write_data;
        end
    end

    ////////////////////
    // Memory port
    ////////////////////

    always_comb begin
        write_port.valid   = memory_write_valid;
        write_port.address = memory_write_address;
        write_port.data    = memory_write_data;
    end

endmodule

// ==== src/fifo_read_controller.sv ====
`timescale 1ns/1ps

module fifo_read_controller (
    input  logic                   read_clock,
    input  logic                   reset_n,
    input  logic                   read_enable,
    input  fifo_pkg::fifo_addr_t   write_pointer_gray,
    output fifo_pkg::memory_read_t read_port,
    output fifo_pkg::fifo_addr_t   read_pointer_gray
);

    import fifo_pkg::*;

    // Binary read pointer to the oldest stored word
    fifo_addr_t read_pointer;
    fifo_addr_t read_pointer_next;

    // Write pointer as seen from the read domain
    fifo_addr_t write_pointer_gray_sync_0;
    fifo_addr_t write_pointer_gray_sync_1;
    fifo_addr_t write_pointer;

    logic       read_accept;
    logic       empty;
    logic       empty_next;

    // Registered memory read request
    logic       memory_read_valid;
    fifo_addr_t memory_read_address;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        write_pointer = gray_to_binary(write_pointer_gray_sync_1);
        read_accept   = read_enable && !empty;

        read_pointer_next = read_pointer;
        if (read_accept) begin
            // Wraps at FIFO_DEPTH minus 1 through the pointer width
            read_pointer_next = read_pointer + 1'b1;
        end

        // Empty uses the pointer after this read and a stale write pointer only delays it
        empty_next = (read_pointer_next == write_pointer);
    end

    ////////////////////
    // Control registers
    ////////////////////

    always_ff @(posedge read_clock or negedge reset_n) begin
        if (!reset_n) begin
            read_pointer              <= '0;
            read_pointer_gray         <= '0;
            write_pointer_gray_sync_0 <= '0;
            write_pointer_gray_sync_1 <= '0;
            memory_read_valid         <= 1'b0;
            empty                     <= 1'b1;
        end
        else begin
            read_pointer              <= read_pointer_next;
            read_pointer_gray         <= binary_to_gray(read_pointer_next);
            write_pointer_gray_sync_0 <= write_pointer_gray;
            write_pointer_gray_sync_1 <= write_pointer_gray_sync_0;
            memory_read_valid         <= read_accept;
            empty                     <= empty_next;
        end
    end

    // Read address qualified by memory_read_valid
    always_ff @(posedge read_clock) begin
        if (read_accept) begin
            memory_read_address <= read_pointer;
        end
    end

    ////////////////////
    // Memory port
    ////////////////////

    always_comb begin
        read_port.valid   = memory_read_valid;
        read_port.address = memory_read_address;
    end

endmodule

// ==== src/fifo_memory.sv ====
`timescale 1ns/1ps

module fifo_memory (
    input  logic                    clock,
    input  logic                    read_clock,
    input  logic                    reset_n,
    input  fifo_pkg::memory_write_t write_port,
    input  fifo_pkg::memory_read_t  read_port,
    output fifo_pkg::fifo_data_t    read_data,
    output logic                    read_data_valid
);

    import fifo_pkg::*;

    fifo_data_t memory [0:FIFO_DEPTH-1];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clock) begin
        if (write_port.valid) begin
            memory[write_port.address] <= write_port.data;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    // Word held until the next request
    always_ff @(posedge read_clock) begin
        if (read_port.valid) begin
            read_data <= memory[read_port.address];
        end
    end

    always_ff @(posedge read_clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data_valid <= 1'b0;
        end
        else begin
            read_data_valid <= read_port.valid;
        end
    end

endmodule

// ==== src/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
    input  logic                 clock,
    input  logic                 read_clock,
    input  logic                 reset_n,

    // Write side, on clock
    input  logic                 write_enable,
    input  fifo_pkg::fifo_data_t write_data,
    output logic                 full,

    // Read side, on read_clock
    input  logic                 read_enable,
    output fifo_pkg::fifo_data_t read_data,
    output logic                 read_data_valid
);

    import fifo_pkg::*;

    memory_write_t write_port;
    memory_read_t  read_port;

    // Gray pointers crossing between the domains
    fifo_addr_t    write_pointer_gray;
    fifo_addr_t    read_pointer_gray;

    ////////////////////
    // Write domain
    ////////////////////

    fifo_write_controller u_write_controller (
        .clock              (clock),
        .reset_n            (reset_n),
        .write_enable       (write_enable),
        .write_data         (write_data),
        .read_pointer_gray  (read_pointer_gray),
        .write_port         (write_port),
        .write_pointer_gray (write_pointer_gray),
        .full               (full)
    );

    ////////////////////
    // Read domain
    ////////////////////

    fifo_read_controller u_read_controller (
        .read_clock         (read_clock),
        .reset_n            (reset_n),
        .read_enable        (read_enable),
        .write_pointer_gray (write_pointer_gray),
        .read_port          (read_port),
        .read_pointer_gray  (read_pointer_gray)
    );

    ////////////////////
    // Storage
    ////////////////////

    fifo_memory u_memory (
        .clock           (clock),
        .read_clock      (read_clock),
        .reset_n         (reset_n),
        .write_port      (write_port),
        .read_port       (read_port),
        .read_data       (read_data),
        .read_data_valid (read_data_valid)
    );

endmodule

// ==== dv/async_fifo_tb.sv ====
`timescale 1ns/1ps

module async_fifo_tb;

    import fifo_pkg::*;

    typedef enum int {
        OP_WRITE,
        OP_READ,
        OP_BOTH,
        OP_IDLE,
        OP_EXPECT
    } stimulus_op_t;

    logic         clock;
    logic         read_clock;
    logic         reset_n;
    logic         write_enable;
    fifo_data_t   write_data;
    logic         full;
    logic         read_enable;
    fifo_data_t   read_data;
    logic         read_data_valid;

    // Parsed stimulus records
    stimulus_op_t record_ops[$];
    int           record_counts[$];
    logic         record_flags[$];
    fifo_data_t   stimulus_words[$];
    bit           stimulus_loaded;

    // Reference model and traffic counters
    fifo_data_t   reference_queue[$];
    int           accepted_count;
    int           read_count;
    int           words_sent;
    bit           writes_done;
    integer       seed;

    async_fifo u_dut (
        .clock           (clock),
        .read_clock      (read_clock),
        .reset_n         (reset_n),
        .write_enable    (write_enable),
        .write_data      (write_data),
        .full            (full),
        .read_enable     (read_enable),
        .read_data       (read_data),
        .read_data_valid (read_data_valid)
    );

    ////////////////////
    // Clocks
    ////////////////////

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Read clock with no relation to clock
    initial begin
        read_clock = 1'b0;
        forever #3.5 read_clock = ~read_clock;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input fifo_data_t expected,
                              input fifo_data_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    ////////////////////
    // Stimulus file
    ////////////////////

    task automatic load_stimulus();
        int               fd;
        int               code;
        int               count;
        int               flag;
        bit               bad_record;
        fifo_data_t       value;
        logic [63:0]      token;
        logic [8*128-1:0] line;
        bad_record = 1'b0;
        fd = $fopen("dv/fifo_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/fifo_stimulus.txt");
            stop_on_failure();
        end
        else begin
            code = $fscanf(fd, "%s", token);
            while (code == 1 && !bad_record) begin
                if (token == 64'("#")) begin
                    code = $fgets(line, fd);
                end
                else if (token == 64'("WRITE") || token == 64'("BOTH")) begin
                    code = $fscanf(fd, "%d", count);
                    bad_record = (code != 1);
                    record_ops.push_back(token == 64'("WRITE") ? OP_WRITE : OP_BOTH);
                    record_counts.push_back(count);
                    record_flags.push_back(1'b0);
                    for (int i = 0; i < count && !bad_record; i++) begin
                        code = $fscanf(fd, "%h", value);
                        bad_record = (code != 1);
                        stimulus_words.push_back(value);
                    end
                end
                else if (token == 64'("READ") || token == 64'("IDLE")) begin
                    code = $fscanf(fd, "%d", count);
                    bad_record = (code != 1);
                    record_ops.push_back(token == 64'("READ") ? OP_READ : OP_IDLE);
                    record_counts.push_back(count);
                    record_flags.push_back(1'b0);
                end
                else if (token == 64'("EXPECT")) begin
                    code = $fscanf(fd, "%d %d", count, flag);
                    bad_record = (code != 2);
                    record_ops.push_back(OP_EXPECT);
                    record_counts.push_back(count);
                    record_flags.push_back(flag != 0);
                end
                else begin
                    bad_record = 1'b1;
                end
                code = $fscanf(fd, "%s", token);
            end
            $fclose(fd);
            if (bad_record) begin
                $display("The stimulus file holds a malformed or unknown record");
                stop_on_failure();
            end
        end
    endtask

    ////////////////////
    // Drivers
    ////////////////////

    function automatic logic random_bit();
        int value;
        value = $random(seed);
        return value[0];
    endfunction

    // Acceptance follows full, which only changes on the rising edge
    task automatic run_writes(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clock);
            write_enable = 1'b1;
            write_data   = stimulus_words.pop_front();
            if (!full) begin
                reference_queue.push_back(write_data);
                accepted_count++;
            end
        end
        @(negedge clock);
        write_enable = 1'b0;
    endtask

    task automatic run_reads(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge read_clock);
            read_enable = 1'b1;
        end
        @(negedge read_clock);
        read_enable = 1'b0;
    endtask

    // Each word is offered until the FIFO takes it while the enables toggle at random
    task automatic run_both(input int count);
        words_sent  = 0;
        writes_done = 1'b0;
        fork
            begin
                while (words_sent < count) begin
                    @(negedge clock);
                    write_enable = random_bit();
                    write_data   = stimulus_words[0];
                    if (write_enable && !full) begin
                        reference_queue.push_back(stimulus_words.pop_front());
                        accepted_count++;
                        words_sent++;
                    end
                end
                @(negedge clock);
                write_enable = 1'b0;
                writes_done  = 1'b1;
            end
            begin
                while (!writes_done) begin
                    @(negedge read_clock);
                    read_enable = random_bit();
                end
                @(negedge read_clock);
                read_enable = 1'b0;
            end
        join
    endtask

    task automatic check_level(input int count, input logic full_expected);
        @(negedge clock);
        check_count("words held in the reference queue", count, reference_queue.size());
        check_flag("full", full_expected, full);
    endtask

    ////////////////////
    // Read side monitor
    ////////////////////

    // Outputs settle half a read_clock cycle before this edge
    always @(negedge read_clock) begin
        if (reset_n && read_data_valid) begin
            if (reference_queue.size() == 0) begin
                $display("read_data_valid was set at %0t with no word left to read", $time);
                stop_on_failure();
            end
            else begin
                check_data("read_data", reference_queue.pop_front(), read_data);
                read_count++;
            end
        end
    end

    initial begin
        wait (stimulus_loaded);
        repeat (record_ops.size() * 200) @(posedge clock);
        $display("Watchdog expired, the run hung after %0d clock cycles",
                 record_ops.size() * 200);
        stop_on_failure();
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed            = 32'hd225;
        reset_n         = 1'b0;
        write_enable    = 1'b0;
        write_data      = '0;
        read_enable     = 1'b0;
        accepted_count  = 0;
        read_count      = 0;
        words_sent      = 0;
        writes_done     = 1'b0;
        stimulus_loaded = 1'b0;

        load_stimulus();
        stimulus_loaded = 1'b1;

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        check_flag("full", 1'b0, full);
        check_flag("read_data_valid", 1'b0, read_data_valid);

        for (int r = 0; r < record_ops.size(); r++) begin
            case (record_ops[r])
                OP_WRITE:  run_writes(record_counts[r]);
                OP_READ:   run_reads(record_counts[r]);
                OP_BOTH:   run_both(record_counts[r]);
                OP_IDLE:   repeat (record_counts[r]) @(negedge clock);
                OP_EXPECT: check_level(record_counts[r], record_flags[r]);
            endcase
        end

        // Every accepted word must have come back out
        check_count("words read", accepted_count, read_count);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== dv/fifo_stimulus.txt ====
# Each record is an opcode, a count and, for WRITE and BOTH, count hex data words
# READ and IDLE counts are cycles, EXPECT gives the queued word count and full
# Read pulse on an empty FIFO
READ 2
IDLE 12
EXPECT 0 0
# Short write, then read back
WRITE 4 1234 abcd 0001 fffe
IDLE 12
EXPECT 4 0
READ 8
IDLE 16
EXPECT 0 0
# Fill with no reads, only 15 of the 20 words fit
WRITE 20
a000 a001 a002 a003 a004 a005 a006 a007 a008 a009
a00a a00b a00c a00d a00e dead beef cafe f00d 5a5a
EXPECT 15 1
# Drain, then extra reads on the empty FIFO
READ 24
IDLE 16
EXPECT 0 0
READ 4
IDLE 12
EXPECT 0 0
# Random writes and reads on both clocks
BOTH 24
c000 c001 c002 c003 c004 c005 c006 c007
c008 c009 c00a c00b c00c c00d c00e c00f
c010 c011 c012 c013 c014 c015 c016 c017
READ 40
IDLE 20
EXPECT 0 0
# Longer random burst
BOTH 32
d000 d001 d002 d003 d004 d005 d006 d007
d008 d009 d00a d00b d00c d00d d00e d00f
d010 d011 d012 d013 d014 d015 d016 d017
d018 d019 d01a d01b d01c d01d d01e d01f
READ 48
IDLE 20
EXPECT 0 0

// ==== flist.f ====
src/fifo_pkg.sv
src/fifo_write_controller.sv
src/fifo_read_controller.sv
src/fifo_memory.sv
src/async_fifo.sv
dv/async_fifo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module async_fifo_tb \
    -f flist.f \
    -o async_fifo_sim

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/async_fifo_sim
